// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := tb_mps_core
FILELIST   := tb.f
VFLAGS     := --binary --timing -j 0 --top-module $(TOP)
LINT_FLAGS := --lint-only --timing --top-module $(TOP)
BUILD_DIR  := obj_dir
LOG        := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q -x ">>> PASS" $(LOG) || (echo "Simulation did not pass"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== src/adc_capture.sv ====
`timescale 1ns/1ns
`include "mps_params.svh"

module adc_capture
(
	input  logic                                         s00_axi_aclk,
	input  logic                                         s00_axi_aresetn,
	input  mps_pkg::adc_bus_t                            i_adc,
	output mps_pkg::adc_hold_t                           o_adc,
	output mps_pkg::phase_sample_t [`MPS_PHASE_NUM-1:0] o_phase
);

	////////////////////////////////////////////////////////////
	// Held channel values

	always_ff @(posedge s00_axi_aclk or negedge s00_axi_aresetn)
	begin
		if (!s00_axi_aresetn)
		begin
			o_adc <= '0;
		end
		else
		begin
			for (int ch = 0; ch < `MPS_ADC_NUM; ch++)
			begin
				if (i_adc[ch].tvalid)
					o_adc[ch] <= i_adc[ch].tdata;   // Otherwise keep last word
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Phase samples for the RMS blocks

	always_ff @(posedge s00_axi_aclk or negedge s00_axi_aresetn)
	begin
		if (!s00_axi_aresetn)
		begin
			o_phase <= '0;
		end
		else
		begin
			for (int ph = 0; ph < `MPS_PHASE_NUM; ph++)
			begin
				o_phase[ph].valid <= i_adc[`MPS_CH_PHASE_R + ph].tvalid;   // Single-cycle strobe
				// Sample payload follows the strobe, low half of the ADC word
				if (i_adc[`MPS_CH_PHASE_R + ph].tvalid)
					o_phase[ph].sample <= i_adc[`MPS_CH_PHASE_R + ph].tdata[`MPS_SAMPLE_W-1:0];
			end
		end
	end

endmodule

// ==== src/mps_axi_regs.sv ====
`timescale 1ns/1ns
`include "mps_params.svh"

module mps_axi_regs
(
	input  logic                                       s00_axi_aclk,
	input  logic                                       s00_axi_aresetn,
	input  mps_pkg::axil_req_t                         i_axil_req,
	output mps_pkg::axil_rsp_t                         o_axil_rsp,
	input  mps_pkg::adc_hold_t                         i_adc,
	input  mps_pkg::rms_result_t [`MPS_PHASE_NUM-1:0] i_rms,
	output mps_pkg::setpoint_t                         o_setpoint
);
	localparam int IDX_W  = $clog2(`MPS_REG_NUM);
	localparam int STRB_W = `MPS_DATA_W / 8;

	logic [IDX_W-1:0]       wr_idx;
	logic [IDX_W-1:0]       rd_idx;
	logic                   wr_accept;
	logic                   rd_accept;
	logic                   bvalid_q;
	logic                   bvalid_d;
	logic                   wr_idle_q;     // Tracks !bvalid, low in reset
	logic                   rvalid_q;
	logic                   rvalid_d;
	logic                   arready_q;
	logic [`MPS_DATA_W-1:0] rdata_q;
	logic [`MPS_DATA_W-1:0] rd_mux;
	mps_pkg::setpoint_t     setpoint_q;

	// Byte-lane merge for a strobed write
	function automatic logic [`MPS_DATA_W-1:0] merge_bytes(
		input logic [`MPS_DATA_W-1:0] old_word,
		input logic [`MPS_DATA_W-1:0] new_word,
		input logic [STRB_W-1:0]      strb
	);
		logic [`MPS_DATA_W-1:0] word;
		word = old_word;
		for (int b = 0; b < STRB_W; b++)
		begin
			if (strb[b])
				word[8*b +: 8] = new_word[8*b +: 8];
		end
		return word;
	endfunction

	assign wr_idx = i_axil_req.awaddr[`MPS_ADDR_W-1:2];   // Word address
	assign rd_idx = i_axil_req.araddr[`MPS_ADDR_W-1:2];

	////////////////////////////////////////////////////////////
	// Write channel

	// Address and data taken together
	assign wr_accept = i_axil_req.awvalid && i_axil_req.wvalid && wr_idle_q;

	always_comb
	begin
		bvalid_d = bvalid_q;
		if (wr_accept)
			bvalid_d = 1'b1;
		else if (i_axil_req.bready)
			bvalid_d = 1'b0;
	end

	always_ff @(posedge s00_axi_aclk or negedge s00_axi_aresetn)
	begin
		if (!s00_axi_aresetn)
		begin
			bvalid_q   <= 1'b0;
			wr_idle_q  <= 1'b0;
			setpoint_q <= '0;
		end
		else
		begin
			bvalid_q  <= bvalid_d;
			wr_idle_q <= !bvalid_d;
			if (wr_accept && (wr_idx == IDX_W'(`MPS_REG_SET_C)))
				setpoint_q.set_c <= merge_bytes(setpoint_q.set_c, i_axil_req.wdata,
					i_axil_req.wstrb);
			if (wr_accept && (wr_idx == IDX_W'(`MPS_REG_SET_V)))
				setpoint_q.set_v <= merge_bytes(setpoint_q.set_v, i_axil_req.wdata,
					i_axil_req.wstrb);
		end
	end

	assign o_setpoint = setpoint_q;

	////////////////////////////////////////////////////////////
	// Read channel

	assign rd_accept = i_axil_req.arvalid && arready_q;

	// Readback mux, unmapped slots give zero
	always_comb
	begin
		rd_mux = '0;
		if (rd_idx == IDX_W'(`MPS_REG_SET_C))
			rd_mux = setpoint_q.set_c;
		if (rd_idx == IDX_W'(`MPS_REG_SET_V))
			rd_mux = setpoint_q.set_v;
		for (int ch = 0; ch < `MPS_ADC_NUM; ch++)
		begin
			if (rd_idx == IDX_W'(`MPS_REG_ADC_BASE + ch))
				rd_mux = i_adc[ch];
		end
		for (int ph = 0; ph < `MPS_PHASE_NUM; ph++)
		begin
			if (rd_idx == IDX_W'(`MPS_REG_RMS_BASE + ph))
				rd_mux = {{(`MPS_DATA_W-`MPS_SAMPLE_W){1'b0}}, i_rms[ph]};
		end
	end

	always_comb
	begin
		rvalid_d = rvalid_q;
		if (rd_accept)
			rvalid_d = 1'b1;
		else if (i_axil_req.rready)
			rvalid_d = 1'b0;
	end

	always_ff @(posedge s00_axi_aclk or negedge s00_axi_aresetn)
	begin
		if (!s00_axi_aresetn)
		begin
			rvalid_q  <= 1'b0;
			arready_q <= 1'b0;
		end
		else
		begin
			rvalid_q  <= rvalid_d;
			arready_q <= !rvalid_d;   // Blocked while a response waits
		end
	end

	always_ff @(posedge s00_axi_aclk)
	begin
		if (rd_accept)
			rdata_q <= rd_mux;     // Stable until rready
	end

	// Responses are always OKAY
	always_comb
	begin
		o_axil_rsp         = '0;
		o_axil_rsp.awready = wr_accept;
		o_axil_rsp.wready  = wr_accept;
		o_axil_rsp.bresp   = 2'b00;
		o_axil_rsp.bvalid  = bvalid_q;
		o_axil_rsp.arready = arready_q;
		o_axil_rsp.rdata   = rdata_q;
		o_axil_rsp.rresp   = 2'b00;
		o_axil_rsp.rvalid  = rvalid_q;
	end

endmodule

// ==== src/mps_core_top.sv ====
`timescale 1ns/1ns
`include "mps_params.svh"

module mps_core_top
(
	input  logic               s00_axi_aclk,
	input  logic               s00_axi_aresetn,
	input  mps_pkg::adc_bus_t  i_adc,
	input  mps_pkg::axil_req_t i_axil_req,
	output mps_pkg::axil_rsp_t o_axil_rsp,
	output mps_pkg::adc_hold_t o_adc,
	output mps_pkg::setpoint_t o_setpoint
);

	mps_pkg::adc_hold_t                         adc_hold;
	mps_pkg::phase_sample_t [`MPS_PHASE_NUM-1:0] phase;    // R, S, T strobes
	mps_pkg::rms_result_t   [`MPS_PHASE_NUM-1:0] rms;

	////////////////////////////////////////////////////////////
	// ADC capture

	adc_capture u_adc_capture
	(
		.s00_axi_aclk    (s00_axi_aclk),
		.s00_axi_aresetn (s00_axi_aresetn),
		.i_adc           (i_adc),
		.o_adc           (adc_hold),
		.o_phase         (phase)
	);

	assign o_adc = adc_hold;

	// One RMS block per phase
	generate
		for (genvar g = 0; g < `MPS_PHASE_NUM; g++)
		begin : g_phase
			phase_rms u_phase_rms
			(
				.s00_axi_aclk    (s00_axi_aclk),
				.s00_axi_aresetn (s00_axi_aresetn),
				.i_sample        (phase[g]),
				.o_rms           (rms[g])
			);
		end
	endgenerate

	////////////////////////////////////////////////////////////
	// Host registers

	mps_axi_regs u_mps_axi_regs
	(
		.s00_axi_aclk    (s00_axi_aclk),
		.s00_axi_aresetn (s00_axi_aresetn),
		.i_axil_req      (i_axil_req),
		.o_axil_rsp      (o_axil_rsp),
		.i_adc           (adc_hold),
		.i_rms           (rms),
		.o_setpoint      (o_setpoint)
	);

endmodule

// ==== src/mps_params.svh ====
`ifndef MPS_PARAMS_SVH
`define MPS_PARAMS_SVH

`define MPS_DATA_W        32    // AXI and ADC word
`define MPS_ADC_NUM       10
`define MPS_PHASE_NUM     3     // R, S, T
`define MPS_SAMPLE_W      16    // Signed phase sample
`define MPS_RMS_WIN_LOG2  4     // 16 samples per window
`define MPS_REG_NUM       32
`define MPS_ADDR_W        7     // Byte address

// Register map, word index
`define MPS_REG_SET_C     0
`define MPS_REG_SET_V     1
// ADC order: c, v, dc_c, dc_v, phase r/s/t, igbt, in ind, out ind
`define MPS_REG_ADC_BASE  2
`define MPS_REG_RMS_BASE  12    // RMS r, s, t

// Phase R position in the ADC array, S and T follow
`define MPS_CH_PHASE_R    4

`endif

// ==== src/mps_pkg.sv ====
`include "mps_params.svh"

package mps_pkg;

	// One ADC channel, no ready on this side
	typedef struct packed {
		logic                   tvalid;
		logic [`MPS_DATA_W-1:0] tdata;
	} adc_stream_t;

	typedef adc_stream_t [`MPS_ADC_NUM-1:0] adc_bus_t;
	typedef logic [`MPS_ADC_NUM-1:0][`MPS_DATA_W-1:0] adc_hold_t;   // Held values

	typedef struct packed {
		logic                            valid;  // One-cycle strobe
		logic signed [`MPS_SAMPLE_W-1:0] sample;
	} phase_sample_t;

	typedef logic [`MPS_SAMPLE_W-1:0] rms_result_t;

	////////////////////////////////////////////////////////////
	// AXI4-Lite
	typedef struct packed {
		logic [`MPS_ADDR_W-1:0]   awaddr;
		logic [2:0]               awprot;
		logic                     awvalid;
		logic [`MPS_DATA_W-1:0]   wdata;
		logic [`MPS_DATA_W/8-1:0] wstrb;
		logic                     wvalid;
		logic                     bready;
		logic [`MPS_ADDR_W-1:0]   araddr;
		logic [2:0]               arprot;
		logic                     arvalid;
		logic                     rready;
	} axil_req_t;

	typedef struct packed {
		logic                   awready;
		logic                   wready;
		logic [1:0]             bresp;
		logic                   bvalid;
		logic                   arready;
		logic [`MPS_DATA_W-1:0] rdata;
		logic [1:0]             rresp;
		logic                   rvalid;
	} axil_rsp_t;

	typedef struct packed {
		logic [`MPS_DATA_W-1:0] set_c;      // Current setpoint
		logic [`MPS_DATA_W-1:0] set_v;      // Voltage setpoint
	} setpoint_t;

endpackage

// ==== src/phase_rms.sv ====
`timescale 1ns/1ns
`include "mps_params.svh"

module phase_rms
(
	input  logic                   s00_axi_aclk,
	input  logic                   s00_axi_aresetn,
	input  mps_pkg::phase_sample_t i_sample,
	output mps_pkg::rms_result_t   o_rms
);
	localparam int SQ_W   = 2 * `MPS_SAMPLE_W;               // One squared sample
	localparam int ACC_W  = SQ_W + `MPS_RMS_WIN_LOG2;        // Sum over the window
	localparam int REM_W  = `MPS_SAMPLE_W + 2;
	localparam int ITER_W = $clog2(`MPS_SAMPLE_W);

	logic signed [SQ_W-1:0]       sq_full;
	logic [ACC_W-1:0]             acc_q;
	logic [ACC_W-1:0]             acc_sum;
	logic [`MPS_RMS_WIN_LOG2-1:0] cnt_q;
	logic                         win_done;
	logic [SQ_W-1:0]              mean_q;
	logic                         mean_vld_q;

	logic [SQ_W-1:0]              rad_q;      // Radicand, consumed two bits per step
	logic [REM_W-1:0]             rem_q;
	logic [REM_W-1:0]             rem_shift;
	logic [REM_W-1:0]             trial;
	logic [`MPS_SAMPLE_W-1:0]     root_q;
	logic [`MPS_SAMPLE_W-1:0]     root_next;
	logic                         take;
	logic                         busy_q;
	logic [ITER_W-1:0]            iter_q;

	////////////////////////////////////////////////////////////
	// Square and accumulate

	assign sq_full  = SQ_W'(i_sample.sample) * SQ_W'(i_sample.sample);
	assign acc_sum  = acc_q + {{(ACC_W-SQ_W){1'b0}}, sq_full};
	assign win_done = i_sample.valid && (cnt_q == '1);     // 16th sample arriving

	always_ff @(posedge s00_axi_aclk)
	begin
		if (win_done)
			mean_q <= acc_sum[ACC_W-1:`MPS_RMS_WIN_LOG2];      // Divide by window length
	end

	always_ff @(posedge s00_axi_aclk or negedge s00_axi_aresetn)
	begin
		if (!s00_axi_aresetn)
		begin
			acc_q      <= '0;
			cnt_q      <= '0;
			mean_vld_q <= 1'b0;
		end
		else
		begin
			mean_vld_q <= win_done;
			if (i_sample.valid)
			begin
				cnt_q <= cnt_q + 1'b1;     // Wraps to zero at window end
				acc_q <= win_done ? '0 : acc_sum;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Restoring square root, one result bit per cycle

	assign rem_shift = {rem_q[REM_W-3:0], rad_q[SQ_W-1 -: 2]};
	assign trial     = {root_q, 2'b01};
	assign take      = (rem_shift >= trial);
	assign root_next = {root_q[`MPS_SAMPLE_W-2:0], take};

	always_ff @(posedge s00_axi_aclk)
	begin
		if (mean_vld_q)
		begin
			rad_q  <= mean_q;
			rem_q  <= '0;
			root_q <= '0;
		end
		else if (busy_q)
		begin
			rad_q  <= rad_q << 2;
			rem_q  <= take ? (rem_shift - trial) : rem_shift;
			root_q <= root_next;
		end
	end

	always_ff @(posedge s00_axi_aclk or negedge s00_axi_aresetn)
	begin
		if (!s00_axi_aresetn)
		begin
			busy_q <= 1'b0;
			iter_q <= '0;
			o_rms  <= '0;
		end
		else if (mean_vld_q)
		begin
			busy_q <= 1'b1;
			iter_q <= '0;
		end
		else if (busy_q)
		begin
			iter_q <= iter_q + 1'b1;
			if (iter_q == '1)
			begin
				busy_q <= 1'b0;
				o_rms  <= root_next;   // Last bit decided this cycle
			end
		end
	end

endmodule

// ==== tb.f ====
+incdir+src
src/mps_pkg.sv
src/adc_capture.sv
src/phase_rms.sv
src/mps_axi_regs.sv
src/mps_core_top.sv
tests/tb_mps_core.sv

// ==== tests/tb_mps_core.sv ====
`timescale 1ns/1ns
`include "mps_params.svh"

module tb_mps_core;

	localparam int addr_w      = `MPS_ADDR_W;
	localparam int timeout_cyc = 64;
	localparam int rms_polls   = 24;      // AXI reads spent waiting for a new RMS
	localparam int win_len     = 1 << `MPS_RMS_WIN_LOG2;

	logic               s00_axi_aclk;
	logic               s00_axi_aresetn;
	mps_pkg::adc_bus_t  adc_in;
	mps_pkg::axil_req_t req;
	mps_pkg::axil_rsp_t rsp;
	mps_pkg::adc_hold_t adc_hold;
	mps_pkg::setpoint_t setpoint;
	integer             seed;
	int                 err_value;
	int                 err_other;

	mps_core_top DUT
	(
		.s00_axi_aclk    (s00_axi_aclk),
		.s00_axi_aresetn (s00_axi_aresetn),
		.i_adc           (adc_in),
		.i_axil_req      (req),
		.o_axil_rsp      (rsp),
		.o_adc           (adc_hold),
		.o_setpoint      (setpoint)
	);

	initial
	begin
		s00_axi_aclk = 1'b0;
		forever #20 s00_axi_aclk = ~s00_axi_aclk;
	end

	////////////////////////////////////////////////////////////
	// Compare helpers

	task automatic flag_error(input string msg);
		$display("Error: %s", msg);
		err_other++;
	endtask

	task automatic check_word(input string name, input logic [`MPS_DATA_W-1:0] exp_v,
		input logic [`MPS_DATA_W-1:0] act_v);
		if (act_v !== exp_v)
		begin
			$display("Fail %s: expected %h, actual %h", name, exp_v, act_v);
			err_value++;
		end
	endtask

	task automatic check_rms(input string name, input mps_pkg::rms_result_t exp_v,
		input mps_pkg::rms_result_t act_v);
		if (act_v !== exp_v)
		begin
			$display("Fail %s: expected %h, actual %h", name, exp_v, act_v);
			err_value++;
		end
	endtask

	task automatic check_setpoint(input string name, input mps_pkg::setpoint_t exp_v,
		input mps_pkg::setpoint_t act_v);
		if (act_v !== exp_v)
		begin
			$display("Fail %s: expected %h, actual %h", name, exp_v, act_v);
			err_value++;
		end
	endtask

	task automatic check_resp(input string name, input logic [1:0] exp_v,
		input logic [1:0] act_v);
		if (act_v !== exp_v)
		begin
			$display("Fail %s: expected %h, actual %h", name, exp_v, act_v);
			err_value++;
		end
	endtask

	function automatic logic [`MPS_ADDR_W-1:0] slot_addr(input int slot);
		return addr_w'(slot * 4);   // Byte address of a word slot
	endfunction

	// Floor square root, one candidate bit at a time from the top
	function automatic mps_pkg::rms_result_t floor_sqrt(input longint value);
		longint r;
		longint t;
		r = 0;
		for (int b = `MPS_SAMPLE_W - 1; b >= 0; b--)
		begin
			t = r + (longint'(1) << b);
			if (t * t <= value)
				r = t;
		end
		return r[`MPS_SAMPLE_W-1:0];
	endfunction

	////////////////////////////////////////////////////////////
	// AXI4-Lite driver

	task automatic axil_write(input logic [`MPS_ADDR_W-1:0] addr,
		input logic [`MPS_DATA_W-1:0] data, input logic [`MPS_DATA_W/8-1:0] strb,
		input int hold);
		int n;
		@(negedge s00_axi_aclk);
		req.awaddr  = addr;
		req.wdata   = data;
		req.wstrb   = strb;
		req.awvalid = 1'b1;
		req.wvalid  = 1'b1;
		#1;    // awready follows the request combinationally
		for (n = 0; n < timeout_cyc && !rsp.awready; n++)
			@(negedge s00_axi_aclk);
		if (!rsp.awready)
			flag_error("write was not accepted within the timeout");
		else if (!rsp.wready)
			flag_error("wready did not rise together with awready");
		@(negedge s00_axi_aclk);       // Taken on the edge just passed
		req.awvalid = 1'b0;
		req.wvalid  = 1'b0;
		for (n = 0; n < timeout_cyc && !rsp.bvalid; n++)
			@(negedge s00_axi_aclk);
		if (!rsp.bvalid)
			flag_error("no write response within the timeout");
		else
			check_resp("write bresp", 2'b00, rsp.bresp);
		repeat (hold)
		begin
			@(negedge s00_axi_aclk);
			if (!rsp.bvalid)
				flag_error("bvalid dropped while bready was low");
		end
		req.bready = 1'b1;
		@(negedge s00_axi_aclk);
		req.bready = 1'b0;
	endtask

	task automatic axil_read(input logic [`MPS_ADDR_W-1:0] addr,
		output logic [`MPS_DATA_W-1:0] data, input int hold);
		int n;
		@(negedge s00_axi_aclk);
		req.araddr  = addr;
		req.arvalid = 1'b1;
		for (n = 0; n < timeout_cyc && !rsp.arready; n++)
			@(negedge s00_axi_aclk);
		if (!rsp.arready)
			flag_error("read address was not accepted within the timeout");
		@(negedge s00_axi_aclk);
		req.arvalid = 1'b0;
		for (n = 0; n < timeout_cyc && !rsp.rvalid; n++)
			@(negedge s00_axi_aclk);
		if (!rsp.rvalid)
			flag_error("no read data within the timeout");
		else
			check_resp("read rresp", 2'b00, rsp.rresp);
		data = rsp.rdata;
		repeat (hold)
		begin
			@(negedge s00_axi_aclk);
			if (!rsp.rvalid || rsp.rdata !== data)
				flag_error("read response changed while rready was low");
		end
		req.rready = 1'b1;
		@(negedge s00_axi_aclk);
		req.rready = 1'b0;
	endtask

	////////////////////////////////////////////////////////////
	// Directed tests

	task automatic test_reset_values();
		logic [`MPS_DATA_W-1:0] rd;
		for (int slot = 0; slot < `MPS_REG_NUM; slot++)
		begin
			axil_read(slot_addr(slot), rd, 0);
			check_word($sformatf("reset slot %0d", slot), '0, rd);
		end
		for (int ch = 0; ch < `MPS_ADC_NUM; ch++)
			check_word($sformatf("reset o_adc %0d", ch), '0, adc_hold[ch]);
		check_setpoint("reset o_setpoint", '0, setpoint);
	endtask

	task automatic test_setpoints();
		mps_pkg::setpoint_t     sp_exp;
		logic [`MPS_DATA_W-1:0] wd;
		logic [`MPS_DATA_W-1:0] rd;
		sp_exp.set_c = $random(seed);
		sp_exp.set_v = $random(seed);
		axil_write(slot_addr(`MPS_REG_SET_C), sp_exp.set_c, 4'hf, 0);
		axil_write(slot_addr(`MPS_REG_SET_V), sp_exp.set_v, 4'hf, 0);
		check_setpoint("setpoint full write", sp_exp, setpoint);
		axil_read(slot_addr(`MPS_REG_SET_C), rd, 0);
		check_word("set_c readback", sp_exp.set_c, rd);
		// Bytes 0 and 2 only
		wd = $random(seed);
		axil_write(slot_addr(`MPS_REG_SET_V), wd, 4'b0101, 0);
		sp_exp.set_v[7:0]   = wd[7:0];
		sp_exp.set_v[23:16] = wd[23:16];
		check_setpoint("setpoint partial strobe", sp_exp, setpoint);
		axil_read(slot_addr(`MPS_REG_SET_V), rd, 0);
		check_word("set_v readback", sp_exp.set_v, rd);
	endtask

	task automatic run_rms_window(input int ph, input int win);
		logic signed [`MPS_SAMPLE_W-1:0] smp;
		longint                          sum_sq;
		mps_pkg::rms_result_t            prev;
		mps_pkg::rms_result_t            cur;
		logic [`MPS_DATA_W-1:0]          rd;
		int                              ch;
		int                              n;
		ch = `MPS_CH_PHASE_R + ph;
		axil_read(slot_addr(`MPS_REG_RMS_BASE + ph), rd, 0);
		prev   = rd[`MPS_SAMPLE_W-1:0];
		sum_sq = 0;
		for (int i = 0; i < win_len; i++)
		begin
			@(negedge s00_axi_aclk);
			adc_in[ch].tdata  = $random(seed);
			adc_in[ch].tvalid = 1'b1;
			smp    = adc_in[ch].tdata[`MPS_SAMPLE_W-1:0];
			sum_sq = sum_sq + longint'(smp) * longint'(smp);
			@(negedge s00_axi_aclk);
			adc_in[ch].tvalid = 1'b0;   // Strobes two cycles apart
		end
		cur = prev;
		for (n = 0; n < rms_polls && cur == prev; n++)
		begin
			axil_read(slot_addr(`MPS_REG_RMS_BASE + ph), rd, 0);
			cur = rd[`MPS_SAMPLE_W-1:0];
		end
		if (cur == prev)
			flag_error($sformatf("RMS of phase %0d was never updated", ph));
		check_rms($sformatf("rms phase %0d window %0d", ph, win),
			floor_sqrt(sum_sq >> `MPS_RMS_WIN_LOG2), cur);
	endtask

	task automatic test_adc_capture();
		logic [`MPS_DATA_W-1:0] exp_adc [`MPS_ADC_NUM];
		logic [`MPS_DATA_W-1:0] rd;
		for (int ch = 0; ch < `MPS_ADC_NUM; ch++)
		begin
			@(negedge s00_axi_aclk);
			exp_adc[ch]       = $random(seed);
			adc_in[ch].tdata  = exp_adc[ch];
			adc_in[ch].tvalid = 1'b1;
			@(negedge s00_axi_aclk);
			adc_in[ch].tvalid = 1'b0;
		end
		// New words without tvalid
		@(negedge s00_axi_aclk);
		for (int ch = 0; ch < `MPS_ADC_NUM; ch++)
			adc_in[ch].tdata = ~exp_adc[ch];
		@(negedge s00_axi_aclk);
		for (int ch = 0; ch < `MPS_ADC_NUM; ch++)
		begin
			check_word($sformatf("o_adc ch %0d", ch), exp_adc[ch], adc_hold[ch]);
			axil_read(slot_addr(`MPS_REG_ADC_BASE + ch), rd, 0);
			check_word($sformatf("adc slot ch %0d", ch), exp_adc[ch], rd);
		end
		axil_write(slot_addr(`MPS_REG_ADC_BASE), ~exp_adc[0], 4'hf, 0);
		axil_read(slot_addr(`MPS_REG_ADC_BASE), rd, 0);
		check_word("ADC slot write ignored", exp_adc[0], rd);
	endtask

	task automatic test_back_pressure();
		logic [`MPS_DATA_W-1:0] wd;
		logic [`MPS_DATA_W-1:0] rd;
		wd = $random(seed);
		axil_write(slot_addr(`MPS_REG_SET_C), wd, 4'hf, 6);
		axil_read(slot_addr(`MPS_REG_SET_C), rd, 6);
		check_word("held read data", wd, rd);
		axil_read(slot_addr(`MPS_REG_RMS_BASE + `MPS_PHASE_NUM), rd, 3);
		check_word("unmapped slot", '0, rd);
	endtask

	initial
	begin
		seed            = 32'h6c644184;
		err_value       = 0;
		err_other       = 0;
		s00_axi_aresetn = 1'b0;
		adc_in          = '0;
		req             = '0;
		repeat (16) @(posedge s00_axi_aclk);
		@(negedge s00_axi_aclk);
		s00_axi_aresetn = 1'b1;

		test_reset_values();
		test_setpoints();
		for (int ph = 0; ph < `MPS_PHASE_NUM; ph++)
		begin
			run_rms_window(ph, 0);
			run_rms_window(ph, 1);    // Second window replaces the first
		end
		test_adc_capture();
		test_back_pressure();

		$display("Errors: %0d wrong values, %0d other failures", err_value, err_other);
		if (err_value == 0 && err_other == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule
